// File: tb.f
+incdir+source
source/u1e_pkg.sv
source/misc_regs.sv
source/pkt_generator.sv
source/sample_fifo.sv
source/rate_pacer.sv
source/u1e_core_lite.sv
tb/u1e_sva.sv
tb/tb_checker.sv
tb/tb_top.sv

// File: run.sh
#!/bin/sh
# build and run the testbench with Verilator

verilator --binary --timing --assert -Wno-fatal -f tb.f \
   --top-module tb_top -Mdir obj_dir -o tb_sim
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

./obj_dir/tb_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "Regression failed" sim.log; then
   exit 1
fi
exit 0

// File: tb/tb_top.sv
////////////////////////////////////////////////////////////////////////////
// testbench top, register and rx stream tests with random stimulus
////////////////////////////////////////////////////////////////////////////
`default_nettype none
`include "u1e_params.svh"

module tb_top;

   timeunit 1ns;
   timeprecision 1ps;

   logic               wb_clk = 1'b0;
   logic               wb_rst;
   logic [10:0]        wb_adr_i;
   u1e_pkg::bus_word_t wb_dat_i, wb_dat_o, switches_i, leds_o;
   logic               wb_we_i, wb_stb_i, wb_cyc_i, wb_ack_o;
   u1e_pkg::frame_word_t rx_data_o;
   logic               rx_src_rdy_o, rx_dst_rdy_i;
   logic               restart;
   logic [15:0]        cur_len;
   int                 word_cnt, chk_errs, fails, tests, failed_tests, mark;
   u1e_pkg::bus_word_t val;
   u1e_pkg::rate_t     rate;

   always #2 wb_clk = ~wb_clk;

   u1e_core_lite dut_i
     (.wb_clk(wb_clk), .wb_rst(wb_rst), .wb_adr_i(wb_adr_i), .wb_dat_i(wb_dat_i),
      .wb_we_i(wb_we_i), .wb_stb_i(wb_stb_i), .wb_cyc_i(wb_cyc_i),
      .wb_dat_o(wb_dat_o), .wb_ack_o(wb_ack_o), .switches_i(switches_i),
      .leds_o(leds_o), .rx_data_o(rx_data_o), .rx_src_rdy_o(rx_src_rdy_o),
      .rx_dst_rdy_i(rx_dst_rdy_i));

   tb_checker checker_i
     (.wb_clk(wb_clk), .wb_rst(wb_rst), .restart_i(restart),
      .enable_i(dut_i.rate_pacer_i.enable_i), .frame_len_i(cur_len),
      .rx_data_i(rx_data_o), .rx_src_rdy_i(rx_src_rdy_o), .rx_dst_rdy_i(rx_dst_rdy_i),
      .word_cnt_o(word_cnt), .err_cnt_o(chk_errs));

   task automatic bus_access(input logic [6:0] adr, input logic we,
                             input logic [15:0] dat, output logic [15:0] rdat);
      int t;
      @(posedge wb_clk);
      wb_adr_i <= {4'd0, adr};
      wb_dat_i <= dat;
      wb_we_i  <= we;
      wb_stb_i <= 1'b1;
      wb_cyc_i <= 1'b1;
      t = 0;
      do
      begin
         @(negedge wb_clk);
         t++;
      end
      while (!wb_ack_o && t < 20);
      if (!wb_ack_o)
      begin
         $display("bus access to address %h got no ack", adr);
         fails++;
      end
      rdat = wb_dat_o;
      @(posedge wb_clk);     // write lands on this edge
      wb_stb_i <= 1'b0;
      wb_cyc_i <= 1'b0;
      wb_we_i  <= 1'b0;
   endtask

   task automatic reg_write(input logic [6:0] adr, input logic [15:0] dat);
      logic [15:0] unused;
      bus_access(adr, 1'b1, dat, unused);
   endtask

   task automatic reg_check(input logic [6:0] adr, input logic [15:0] exp,
                            input logic [15:0] mask);
      logic [15:0] got;
      bus_access(adr, 1'b0, 16'd0, got);
      if ((got & mask) !== (exp & mask))
      begin
         $display("mismatch wb_dat_o at %h: got %h expected %h", adr, got & mask,
                  exp & mask);
         fails++;
      end
   endtask

   // stop the stream, set the length, clear, and restart the model
   task automatic restart_stream(input logic [15:0] len);
      reg_write(`U1E_REG_XFER_RATE, 16'h0000);
      @(posedge wb_clk);
      rx_dst_rdy_i <= 1'b0;
      reg_write(`U1E_REG_FRAME_LEN, len);
      reg_write(`U1E_REG_CLEAR, 16'h0001);
      @(posedge wb_clk);
      restart <= 1'b1;
      cur_len <= len;
      @(posedge wb_clk);
      restart <= 1'b0;
   endtask

   task automatic stream_words(input int n, input logic rnd_dst);
      int t;
      int base;
      base = word_cnt;
      t = 0;
      while (word_cnt < base + n && t < 4000)
      begin
         @(posedge wb_clk);
         if (rnd_dst)
            rx_dst_rdy_i <= 1'($urandom % 2);
         @(negedge wb_clk);
         t++;
      end
      if (word_cnt < base + n)
      begin
         $display("timed out waiting for %0d rx words", n);
         fails++;
      end
   endtask

   task automatic end_test(input string name);
      tests++;
      if (fails + chk_errs != mark)
      begin
         failed_tests++;
         $display("test %0d %s: FAIL", tests, name);
      end
      else
         $display("test %0d %s: ok", tests, name);
      mark = fails + chk_errs;
   endtask

   initial
   begin
      void'($urandom(32'hf6d0_fd9b));
      wb_rst <= 1'b1;
      {wb_adr_i, wb_dat_i, wb_we_i, wb_stb_i, wb_cyc_i} <= '0;
      switches_i   <= '0;
      rx_dst_rdy_i <= 1'b0;
      restart      <= 1'b0;
      cur_len      <= '0;
      fails = 0;
      tests = 0;
      failed_tests = 0;
      mark = 0;
      repeat (2) @(posedge wb_clk);
      wb_rst <= 1'b0;

      ////////////////////////////////////////////////////////////////////////////
      // register access
      reg_check(`U1E_REG_LEDS, 16'h0, 16'hffff);
      reg_check(`U1E_REG_TEST, 16'h0, 16'hffff);
      reg_check(`U1E_REG_FRAME_LEN, 16'h0, 16'hffff);
      reg_check(`U1E_REG_XFER_RATE, 16'h0, 16'hffff);
      reg_check(`U1E_REG_STATUS, 16'h0002, 16'hffff);  // only fifo empty
      val = 16'($urandom);
      reg_write(`U1E_REG_LEDS, val);
      reg_check(`U1E_REG_LEDS, val, 16'hffff);
      if (leds_o !== val)
      begin
         $display("mismatch leds_o: got %h expected %h", leds_o, val);
         fails++;
      end
      val = 16'($urandom);
      reg_write(`U1E_REG_TEST, val);
      reg_check(`U1E_REG_TEST, val, 16'hffff);
      val = 16'($urandom);
      reg_write(`U1E_REG_FRAME_LEN, val);
      reg_check(`U1E_REG_FRAME_LEN, val, 16'hffff);
      val = 16'($urandom);
      reg_write(`U1E_REG_XFER_RATE, val);
      reg_check(`U1E_REG_XFER_RATE, val, 16'hffff);
      val = 16'($urandom);
      @(posedge wb_clk);
      switches_i <= val;
      reg_check(`U1E_REG_SWITCHES, val, 16'hffff);
      reg_check(7'd4, `U1E_READ_DEFAULT, 16'hffff);
      end_test("register access");

      // plain stream, sink always ready
      restart_stream(16'(1 + $urandom % 8));
      reg_write(`U1E_REG_XFER_RATE, 16'h8000);
      @(posedge wb_clk);
      rx_dst_rdy_i <= 1'b1;
      stream_words(60, 1'b0);
      end_test("packet stream");

      // random back-pressure, then disabled with the sink still random
      rate = 8'($urandom % 4);
      restart_stream(16'(1 + $urandom % 8));
      reg_write(`U1E_REG_XFER_RATE, {8'h80, rate});
      stream_words(80, 1'b1);
      reg_write(`U1E_REG_XFER_RATE, 16'h0000);
      repeat (30)
      begin
         @(posedge wb_clk);
         rx_dst_rdy_i <= 1'($urandom % 2);
      end
      end_test("back-pressure");

      ////////////////////////////////////////////////////////////////////////////
      // overrun, none at rate 7 with a ready sink, then a stalled sink
      restart_stream(16'd4);
      reg_write(`U1E_REG_XFER_RATE, 16'h8007);
      @(posedge wb_clk);
      rx_dst_rdy_i <= 1'b1;
      stream_words(12, 1'b0);
      reg_check(`U1E_REG_STATUS, 16'h0000, 16'h0001);
      restart_stream(16'd4);
      reg_write(`U1E_REG_XFER_RATE, 16'h8002);
      repeat (40) @(posedge wb_clk);
      reg_check(`U1E_REG_STATUS, 16'h0001, 16'h0001);
      end_test("overrun");

      // clear drops the FIFO and the overrun flag
      restart_stream(16'd3);
      reg_check(`U1E_REG_STATUS, 16'h0002, 16'h0003);
      reg_write(`U1E_REG_XFER_RATE, 16'h8000);
      @(posedge wb_clk);
      rx_dst_rdy_i <= 1'b1;
      stream_words(5, 1'b0);   // first word must be seq 0, index 0
      end_test("clear");

      $display("tests %0d, failed %0d, words checked %0d, errors %0d",
               tests, failed_tests, word_cnt, fails + chk_errs);
      if (fails + chk_errs == 0)
         $display("Regression passed");
      else
         $display("Regression failed");
      $finish;
   end

endmodule

`default_nettype wire

// File: tb/tb_checker.sv
////////////////////////////////////////////////////////////////////////////
// packet stream model and comparer on the rx port
////////////////////////////////////////////////////////////////////////////
`default_nettype none

module tb_checker
  (
   input  wire logic                  wb_clk,
   input  wire logic                  wb_rst,
   input  wire logic                  restart_i,   // model restart on clear write
   input  wire logic                  enable_i,
   input  wire logic [15:0]           frame_len_i,
   input  wire u1e_pkg::frame_word_t  rx_data_i,
   input  wire logic                  rx_src_rdy_i,
   input  wire logic                  rx_dst_rdy_i,
   output int                         word_cnt_o,
   output int                         err_cnt_o
   );

   timeunit 1ns;
   timeprecision 1ps;

   logic [15:0] exp_seq;
   logic [15:0] exp_idx;
   logic        prev_src;

   function automatic logic [15:0] last_index(input logic [15:0] len);
      if (len == 16'd0)
         return 16'd0;       // zero length acts as one
      return len - 16'd1;
   endfunction

   function automatic u1e_pkg::frame_word_t expected_word(input logic [15:0] seq,
                                                          input logic [15:0] idx,
                                                          input logic [15:0] len);
      logic sof;
      logic eof;
      sof = (idx == 16'd0);
      eof = (idx == last_index(len));
      return {2'b00, eof, sof, seq, idx};
   endfunction

   initial
   begin
      word_cnt_o = 0;
      err_cnt_o  = 0;
   end

   always @(posedge wb_clk)
   begin
      if (wb_rst || restart_i)
      begin
         exp_seq  <= '0;
         exp_idx  <= '0;
         prev_src <= 1'b0;
      end
      else
      begin
         prev_src <= rx_src_rdy_i;
         if (!enable_i && rx_src_rdy_i && !prev_src)
         begin
            $display("rx_src_rdy_o rose while the stream was disabled");
            err_cnt_o <= err_cnt_o + 1;
         end
         if (rx_src_rdy_i && rx_dst_rdy_i)
         begin
            if (rx_data_i !== expected_word(exp_seq, exp_idx, frame_len_i))
            begin
               $display("mismatch rx_data_o: got %h expected %h", rx_data_i,
                        expected_word(exp_seq, exp_idx, frame_len_i));
               err_cnt_o <= err_cnt_o + 1;
            end
            word_cnt_o <= word_cnt_o + 1;
            if (exp_idx == last_index(frame_len_i))
            begin
               exp_idx <= '0;
               exp_seq <= exp_seq + 16'd1;   // wraps
            end
            else
               exp_idx <= exp_idx + 16'd1;
         end
      end
   end

endmodule

`default_nettype wire

// File: tb/u1e_sva.sv
////////////////////////////////////////////////////////////////////////////
// rx handshake and reset assertions, bound into every rate_pacer
////////////////////////////////////////////////////////////////////////////
`default_nettype none

module u1e_sva
  (
   input wire logic                  wb_clk,
   input wire logic                  wb_rst,
   input wire logic                  clear_i,
   input wire logic                  empty_i,
   input wire logic                  rd_o,
   input wire u1e_pkg::frame_word_t  rx_data_o,
   input wire logic                  rx_src_rdy_o,
   input wire logic                  rx_dst_rdy_i
   );

   timeunit 1ns;
   timeprecision 1ps;

   // nothing offered once reset has been seen
   src_low_in_reset: assert property (@(posedge wb_clk) wb_rst |=> !rx_src_rdy_o)
      else $error("rx_src_rdy_o high during reset");

   // offered word holds while the sink stalls
   hold_on_stall: assert property (@(posedge wb_clk) disable iff (wb_rst)
      (rx_src_rdy_o && !rx_dst_rdy_i && !clear_i) |=> (rx_src_rdy_o && $stable(rx_data_o)))
      else $error("rx word changed while stalled");

   // reset and clear leave the FIFO empty with nothing popped
   empty_after_clear: assert property (@(posedge wb_clk)
      (wb_rst || clear_i) |=> (empty_i && !rd_o))
      else $error("FIFO not empty or popped after reset or clear");

endmodule

bind rate_pacer u1e_sva sva_i
  (.wb_clk(wb_clk), .wb_rst(wb_rst), .clear_i(clear_i), .empty_i(empty_i),
   .rd_o(rd_o), .rx_data_o(rx_data_o), .rx_src_rdy_o(rx_src_rdy_o),
   .rx_dst_rdy_i(rx_dst_rdy_i));

`default_nettype wire

// File: source/u1e_core_lite.sv
////////////////////////////////////////////////////////////////////////////
// lite core top, register slave plus paced receive test path
// generator -> sample FIFO -> pacer -> rx port
////////////////////////////////////////////////////////////////////////////
`default_nettype none
`include "u1e_params.svh"

module u1e_core_lite
  (
   input  logic                  wb_clk,
   input  logic                  wb_rst,
   input  logic [`U1E_AW-1:0]    wb_adr_i,
   input  u1e_pkg::bus_word_t    wb_dat_i,
   input  logic                  wb_we_i,
   input  logic                  wb_stb_i,
   input  logic                  wb_cyc_i,
   output u1e_pkg::bus_word_t    wb_dat_o,
   output logic                  wb_ack_o,
   input  u1e_pkg::bus_word_t    switches_i,
   output u1e_pkg::bus_word_t    leds_o,
   output u1e_pkg::frame_word_t  rx_data_o,
   output logic                  rx_src_rdy_o,
   input  logic                  rx_dst_rdy_i
   );

   u1e_pkg::bus_word_t   frame_len;
   u1e_pkg::rate_t       rate;
   u1e_pkg::frame_word_t gen_data, head_data;
   logic                 enable, clear, overrun;
   logic                 gen_wr, fifo_full, fifo_empty, pacer_rd;

   ////////////////////////////////////////////////////////////////////////////
   // control registers
   misc_regs misc_regs_i
     (.wb_clk(wb_clk), .wb_rst(wb_rst),
      .wb_adr_i(wb_adr_i), .wb_dat_i(wb_dat_i), .wb_we_i(wb_we_i),
      .wb_stb_i(wb_stb_i), .wb_cyc_i(wb_cyc_i),
      .wb_dat_o(wb_dat_o), .wb_ack_o(wb_ack_o),
      .switches_i(switches_i), .overrun_i(overrun), .fifo_empty_i(fifo_empty),
      .leds_o(leds_o), .frame_len_o(frame_len),
      .enable_o(enable), .rate_o(rate), .clear_o(clear));

   ////////////////////////////////////////////////////////////////////////////
   // receive path
   pkt_generator pkt_generator_i
     (.wb_clk(wb_clk), .wb_rst(wb_rst), .clear_i(clear), .enable_i(enable),
      .frame_len_i(frame_len), .full_i(fifo_full),
      .wr_o(gen_wr), .data_o(gen_data));

   sample_fifo sample_fifo_i
     (.wb_clk(wb_clk), .wb_rst(wb_rst), .clear_i(clear),
      .wr_i(gen_wr), .data_i(gen_data), .rd_i(pacer_rd),
      .data_o(head_data), .full_o(fifo_full), .empty_o(fifo_empty));

   rate_pacer rate_pacer_i
     (.wb_clk(wb_clk), .wb_rst(wb_rst), .clear_i(clear),
      .enable_i(enable), .rate_i(rate),
      .empty_i(fifo_empty), .head_i(head_data), .rd_o(pacer_rd),
      .rx_data_o(rx_data_o), .rx_src_rdy_o(rx_src_rdy_o),
      .rx_dst_rdy_i(rx_dst_rdy_i), .overrun_o(overrun));

endmodule

`default_nettype wire

// File: source/rate_pacer.sv
////////////////////////////////////////////////////////////////////////////
// releases one FIFO word per pacing tick on the rx port with
// src/dst ready handshake, flags ticks lost while credit is held
////////////////////////////////////////////////////////////////////////////
`default_nettype none

module rate_pacer
  (
   input  logic                  wb_clk,
   input  logic                  wb_rst,
   input  logic                  clear_i,
   input  logic                  enable_i,
   input  u1e_pkg::rate_t        rate_i,
   input  logic                  empty_i,
   input  u1e_pkg::frame_word_t  head_i,
   output logic                  rd_o,
   output u1e_pkg::frame_word_t  rx_data_o,
   output logic                  rx_src_rdy_o,
   input  logic                  rx_dst_rdy_i,
   output logic                  overrun_o
   );

   u1e_pkg::rate_t tick_cnt;
   logic           tick;
   logic           credit;
   logic           stall_q;       // word offered last cycle and not taken
   logic           xfer;

   assign tick = enable_i && (tick_cnt >= rate_i);

   // a word already offered stays up even if enable drops
   assign rx_src_rdy_o = credit & ~empty_i & (enable_i | stall_q);
   assign rx_data_o    = head_i;
   assign xfer         = rx_src_rdy_o & rx_dst_rdy_i;
   assign rd_o         = xfer;

   always_ff @(posedge wb_clk)
   begin
      if (wb_rst || clear_i)
      begin
         tick_cnt  <= '0;
         credit    <= 1'b0;
         stall_q   <= 1'b0;
         overrun_o <= 1'b0;
      end
      else
      begin
         if (!enable_i || tick)
            tick_cnt <= '0;
         else
            tick_cnt <= tick_cnt + 8'd1;

         if (tick)
            credit <= 1'b1;
         else if (xfer)
            credit <= 1'b0;

         if (tick && credit && !xfer)
            overrun_o <= 1'b1;           // sticky
         stall_q <= rx_src_rdy_o & ~rx_dst_rdy_i;
      end
   end

endmodule

`default_nettype wire

// File: source/sample_fifo.sv
////////////////////////////////////////////////////////////////////////////
// register array FIFO of framed words, head word shown while not empty;
// clear drops everything held
////////////////////////////////////////////////////////////////////////////
`default_nettype none
`include "u1e_params.svh"

module sample_fifo
  (
   input  logic                  wb_clk,
   input  logic                  wb_rst,
   input  logic                  clear_i,
   input  logic                  wr_i,
   input  u1e_pkg::frame_word_t  data_i,
   input  logic                  rd_i,
   output u1e_pkg::frame_word_t  data_o,
   output logic                  full_o,
   output logic                  empty_o
   );

   localparam int DEPTH = 1 << `U1E_FIFO_AW;

   u1e_pkg::frame_word_t   mem [DEPTH];
   logic [`U1E_FIFO_AW-1:0] wr_ptr, rd_ptr;
   logic [`U1E_FIFO_AW:0]   count;
   logic                    do_wr, do_rd;

   assign full_o  = (count == DEPTH[`U1E_FIFO_AW:0]);
   assign empty_o = (count == '0);
   assign do_wr   = wr_i & ~full_o;
   assign do_rd   = rd_i & ~empty_o;
   assign data_o  = mem[rd_ptr];

   always_ff @(posedge wb_clk)
   begin
      if (do_wr)
         mem[wr_ptr] <= data_i;
   end

   always_ff @(posedge wb_clk)
   begin
      if (wb_rst || clear_i)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (do_wr)
            wr_ptr <= wr_ptr + 1'b1;
         if (do_rd)
            rd_ptr <= rd_ptr + 1'b1;
         case ({do_wr, do_rd})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: ;                       // both or neither
         endcase
      end
   end

endmodule

`default_nettype wire

// File: source/pkt_generator.sv
////////////////////////////////////////////////////////////////////////////
// counting packet source, pushes framed words into the sample FIFO
// whenever enabled and there is room
////////////////////////////////////////////////////////////////////////////
`default_nettype none

module pkt_generator
  (
   input  logic                  wb_clk,
   input  logic                  wb_rst,
   input  logic                  clear_i,
   input  logic                  enable_i,
   input  u1e_pkg::bus_word_t    frame_len_i,
   input  logic                  full_i,
   output logic                  wr_o,
   output u1e_pkg::frame_word_t  data_o
   );

   logic [15:0] seq_num;
   logic [15:0] word_idx;
   logic [15:0] last_idx;
   logic        sof, eof;

   // a length of 0 behaves as 1
   assign last_idx = (frame_len_i == '0) ? 16'd0 : frame_len_i - 16'd1;

   assign sof = (word_idx == 16'd0);
   assign eof = (word_idx >= last_idx);     // also covers a length cut mid packet

   assign wr_o   = enable_i & ~full_i & ~clear_i;
   assign data_o = {2'b00, eof, sof, seq_num, word_idx};

   always_ff @(posedge wb_clk)
   begin
      if (wb_rst || clear_i)
      begin
         seq_num  <= '0;
         word_idx <= '0;
      end
      else if (wr_o)
      begin
         if (eof)
         begin
            word_idx <= '0;
            seq_num  <= seq_num + 16'd1;    // wraps at 16 bits
         end
         else
            word_idx <= word_idx + 16'd1;
      end
   end

endmodule

`default_nettype wire

// File: source/misc_regs.sv
////////////////////////////////////////////////////////////////////////////
// wishbone slave with LEDs, switches, test, frame length, rate, status
// and clear; ack is combinational so every access ends in one cycle
////////////////////////////////////////////////////////////////////////////
`default_nettype none
`include "u1e_params.svh"

module misc_regs
  (
   input  logic                  wb_clk,
   input  logic                  wb_rst,
   input  logic [`U1E_AW-1:0]    wb_adr_i,
   input  u1e_pkg::bus_word_t    wb_dat_i,
   input  logic                  wb_we_i,
   input  logic                  wb_stb_i,
   input  logic                  wb_cyc_i,
   output u1e_pkg::bus_word_t    wb_dat_o,
   output logic                  wb_ack_o,
   input  u1e_pkg::bus_word_t    switches_i,
   input  logic                  overrun_i,
   input  logic                  fifo_empty_i,
   output u1e_pkg::bus_word_t    leds_o,
   output u1e_pkg::bus_word_t    frame_len_o,
   output logic                  enable_o,
   output u1e_pkg::rate_t        rate_o,
   output logic                  clear_o
   );

   u1e_pkg::bus_word_t reg_leds, reg_test, reg_frame_len, reg_xfer_rate;
   logic [6:0]         reg_adr;
   logic               wr_stb;

   assign reg_adr = wb_adr_i[6:0];
   assign wr_stb  = wb_stb_i & wb_cyc_i & wb_we_i;

   ////////////////////////////////////////////////////////////////////////////
   // writable registers
   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
      begin
         reg_leds      <= '0;
         reg_test      <= '0;
         reg_frame_len <= '0;
         reg_xfer_rate <= '0;
         clear_o       <= 1'b0;
      end
      else
      begin
         clear_o <= wr_stb && (reg_adr == `U1E_REG_CLEAR);   // one cycle pulse
         if (wr_stb)
         begin
            case (reg_adr)
               `U1E_REG_LEDS:      reg_leds      <= wb_dat_i;
               `U1E_REG_TEST:      reg_test      <= wb_dat_i;
               `U1E_REG_FRAME_LEN: reg_frame_len <= wb_dat_i;
               `U1E_REG_XFER_RATE: reg_xfer_rate <= wb_dat_i;
               default: ;
            endcase
         end
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // read mux, status and switches are live
   always_comb
   begin
      case (reg_adr)
         `U1E_REG_LEDS:      wb_dat_o = reg_leds;
         `U1E_REG_SWITCHES:  wb_dat_o = switches_i;
         `U1E_REG_CLEAR:     wb_dat_o = '0;             // write only
         `U1E_REG_TEST:      wb_dat_o = reg_test;
         `U1E_REG_STATUS:    wb_dat_o = {14'd0, fifo_empty_i, overrun_i};
         `U1E_REG_FRAME_LEN: wb_dat_o = reg_frame_len;
         `U1E_REG_XFER_RATE: wb_dat_o = reg_xfer_rate;
         default:            wb_dat_o = `U1E_READ_DEFAULT;
      endcase
   end

   assign wb_ack_o = wb_stb_i & wb_cyc_i;

   assign leds_o      = reg_leds;
   assign frame_len_o = reg_frame_len;
   assign enable_o    = reg_xfer_rate[15];
   assign rate_o      = reg_xfer_rate[7:0];

endmodule

`default_nettype wire

// File: source/u1e_pkg.sv
////////////////////////////////////////////////////////////////////////////
// shared data types of the lite core, referenced as u1e_pkg::name
////////////////////////////////////////////////////////////////////////////
`default_nettype none
`include "u1e_params.svh"

package u1e_pkg;

   // register and bus data word
   typedef logic [`U1E_DW-1:0] bus_word_t;

   // framed receive word
   //   35:34  zero
   //   33     end of frame
   //   32     start of frame
   //   31:16  packet sequence number
   //   15:0   word index within packet
   typedef logic [`U1E_WORD_W-1:0] frame_word_t;

   // pacing rate, one tick every rate+1 cycles
   typedef logic [7:0] rate_t;

endpackage

`default_nettype wire

// File: source/u1e_params.svh
////////////////////////////////////////////////////////////////////////////
// bus widths, register map and FIFO depth for the lite receive core
// included by the RTL and the testbench
////////////////////////////////////////////////////////////////////////////
`ifndef U1E_PARAMS_SVH
`define U1E_PARAMS_SVH

`define U1E_DW            16       // wishbone data width
`define U1E_AW            11       // wishbone address width
`define U1E_WORD_W        36       // framed word, sof/eof on 33:32
`define U1E_FIFO_AW       4        // 16 entries

// byte addresses, decoded on adr[6:0]
`define U1E_REG_LEDS      7'd0
`define U1E_REG_SWITCHES  7'd2
`define U1E_REG_CLEAR     7'd6
`define U1E_REG_TEST      7'd8
`define U1E_REG_STATUS    7'd10
`define U1E_REG_FRAME_LEN 7'd12
`define U1E_REG_XFER_RATE 7'd14

`define U1E_READ_DEFAULT  16'hBEEF

`endif
